//--- common/trace_consts.svh
/*
 * Sizing constants of the retirement trace unit:
 * reorder queue depth, fixed slot positions for each event source,
 * vector lane count, cache line geometry and field widths
 */
`ifndef TRACE_CONSTS_SVH
`define TRACE_CONSTS_SVH

// Reorder queue depth and slot positions
`define TRACE_QUEUE_LEN          7
`define TRACE_SLOT_MULTI         0
`define TRACE_SLOT_MEM           3
// Store invalidation also acts on this slot
`define TRACE_SLOT_SCYCLE        4
`define TRACE_SLOT_STORE         5
`define TRACE_SLOT_IDX_WIDTH     3

// Datapath geometry
`define VECTOR_LANES             4
`define SCALAR_WIDTH             32
`define CACHE_LINE_BYTES         16
`define CACHE_LINE_OFFSET_WIDTH  4

// Thread and register file sizes
`define THREAD_IDX_WIDTH         2
`define REGISTER_IDX_WIDTH       5

// Width of the emitted record counter, which wraps
`define TRACE_SEQ_WIDTH          16

`endif

//--- common/trace_pkg.sv
/*
 * Shared types of the retirement trace unit:
 * scalar, vector, index and mask types, pipeline and event enums,
 * input info structs, slot write requests and the output record
 */
`include "trace_consts.svh"

package trace_pkg;

    typedef logic [`SCALAR_WIDTH - 1:0] scalar_t;
    typedef logic [`VECTOR_LANES * `SCALAR_WIDTH - 1:0] vector_t;
    typedef logic [`THREAD_IDX_WIDTH - 1:0] thread_idx_t;
    typedef logic [`REGISTER_IDX_WIDTH - 1:0] register_idx_t;
    typedef logic [`VECTOR_LANES - 1:0] lane_mask_t;
    typedef logic [`CACHE_LINE_BYTES - 1:0] line_mask_t;

    // Pipeline that produced a writeback
    typedef enum logic [1:0] {
        PIPE_MEM,
        PIPE_SCYCLE_ARITH,
        PIPE_MCYCLE_ARITH
    } pipeline_sel_t;

    typedef enum logic [2:0] {
        EVENT_INVALID = 0,
        EVENT_SWRITEBACK,
        EVENT_VWRITEBACK,
        EVENT_STORE,
        EVENT_INTERRUPT
    } trace_event_type_t;

    // One entry of the reorder queue and of the output record
    typedef struct packed {
        trace_event_type_t event_type;
        scalar_t pc;
        thread_idx_t thread_idx;
        register_idx_t writeback_reg;
        scalar_t addr;
        line_mask_t mask;
        vector_t data;
    } trace_event_t;

    // Retirement seen at the writeback stage
    typedef struct packed {
        logic en;
        logic is_vector;
        logic is_sync_store;
        pipeline_sel_t pipeline;
        thread_idx_t thread_idx;
        register_idx_t writeback_reg;
        scalar_t pc;
        vector_t value;
        lane_mask_t mask;
    } writeback_info_t;

    // Store leaving the memory pipeline, already line aligned in data and mask
    typedef struct packed {
        logic en;
        scalar_t pc;
        thread_idx_t thread_idx;
        scalar_t virt_addr;
        line_mask_t mask;
        vector_t data;
    } store_info_t;

    typedef struct packed {
        logic instruction_valid;
        logic is_load;
        logic is_sync;
        logic rollback_en;
        logic sync_success;
    } mem_status_t;

    typedef struct packed {
        logic en;
        thread_idx_t thread_idx;
        scalar_t pc;
    } interrupt_info_t;

    typedef struct packed {
        logic valid;
        logic [`TRACE_SLOT_IDX_WIDTH - 1:0] slot;
        trace_event_t evt;
    } slot_write_t;

    typedef struct packed {
        trace_event_t evt;
        logic [`TRACE_SEQ_WIDTH - 1:0] seq;
    } trace_record_t;

endpackage

//--- logic/writeback_capture.sv
/*
 * Writeback stage capture
 * Converts a retiring register writeback into a reorder queue slot write,
 * placing it according to the pipeline that produced it
 */
`timescale 1ns/1ps
`include "trace_consts.svh"

module writeback_capture(
    input  trace_pkg::writeback_info_t wb,
    input  logic                       trace_en,
    output trace_pkg::slot_write_t     slot_write
);

    logic [`TRACE_SLOT_IDX_WIDTH - 1:0] target_slot;
    trace_pkg::line_mask_t              wide_mask;

    // Slower pipelines retire later, so they land closer to the queue head
    always_comb
    begin
        case (wb.pipeline)
            trace_pkg::PIPE_MEM:
                target_slot = `TRACE_SLOT_IDX_WIDTH'(`TRACE_SLOT_MEM);

            trace_pkg::PIPE_SCYCLE_ARITH:
                target_slot = `TRACE_SLOT_IDX_WIDTH'(`TRACE_SLOT_SCYCLE);

            default:
                target_slot = `TRACE_SLOT_IDX_WIDTH'(`TRACE_SLOT_MULTI);
        endcase
    end

    // Lane mask sits in the low bits of the line mask
    assign wide_mask = {{(`CACHE_LINE_BYTES - `VECTOR_LANES){1'b0}}, wb.mask};

    always_comb
    begin
        slot_write = '0;
        slot_write.slot = target_slot;

        // A synchronized store only reports its memory event, the success
        // value written to the register is left out of the trace
        if (trace_en && wb.en && !wb.is_sync_store)
        begin
            slot_write.valid = 1'b1;
            if (wb.is_vector)
                slot_write.evt.event_type = trace_pkg::EVENT_VWRITEBACK;
            else
                slot_write.evt.event_type = trace_pkg::EVENT_SWRITEBACK;

            slot_write.evt.pc = wb.pc;
            slot_write.evt.thread_idx = wb.thread_idx;
            slot_write.evt.writeback_reg = wb.writeback_reg;
            slot_write.evt.mask = wide_mask;
            slot_write.evt.data = wb.value;
        end
    end

endmodule

//--- logic/memory_trap_capture.sv
/*
 * Memory pipeline and trap capture
 * Builds store and interrupt events for the store slot, and flags stores
 * that were rolled back or whose synchronized write failed
 */
`timescale 1ns/1ps
`include "trace_consts.svh"

module memory_trap_capture(
    input  trace_pkg::store_info_t     store,
    input  trace_pkg::mem_status_t     status,
    input  trace_pkg::interrupt_info_t interrupt,
    input  logic                       trace_en,
    output trace_pkg::slot_write_t     slot_write,
    output logic                       store_invalidate
);

    trace_pkg::scalar_t line_addr;
    logic               sync_store_failed;

    // Stores are traced per cache line, so drop the offset bits
    assign line_addr = {
        store.virt_addr[`SCALAR_WIDTH - 1:`CACHE_LINE_OFFSET_WIDTH],
        {`CACHE_LINE_OFFSET_WIDTH{1'b0}}
    };

    always_comb
    begin
        slot_write = '0;
        slot_write.slot = `TRACE_SLOT_IDX_WIDTH'(`TRACE_SLOT_STORE);

        if (trace_en && store.en)
        begin
            slot_write.valid = 1'b1;
            slot_write.evt.event_type = trace_pkg::EVENT_STORE;
            slot_write.evt.pc = store.pc;
            slot_write.evt.thread_idx = store.thread_idx;
            slot_write.evt.addr = line_addr;
            slot_write.evt.mask = store.mask;
            slot_write.evt.data = store.data;
        end
        else if (trace_en && interrupt.en)
        begin
            // Interrupts ride down the integer pipeline on an instruction
            slot_write.valid = 1'b1;
            slot_write.evt.event_type = trace_pkg::EVENT_INTERRUPT;
            slot_write.evt.pc = interrupt.pc;
            slot_write.evt.thread_idx = interrupt.thread_idx;
        end
    end

    assign sync_store_failed = status.is_sync && !status.is_load && !status.sync_success;

    // The store queue reports these one cycle after the store itself, and
    // the queue drops the store if it has reached the invalidation slot.
    // This is not gated by trace_en so a store already in flight is still dropped
    assign store_invalidate = status.instruction_valid
        && (status.rollback_en || sync_store_failed);

    // Stores and interrupts share one slot and may never retire together
    always_comb
    begin
        assert final (!(store.en && interrupt.en))
        else
            $error("Store and interrupt retired in the same cycle");
    end

endmodule

//--- reorder/trace_reorder_queue.sv
/*
 * Reorder queue
 * Fixed-slot shift queue that moves every event one slot toward the head
 * each cycle, so events written at a later slot catch up to issue order.
 * Also holds the store invalidation rule and the slot collision checks
 */
`timescale 1ns/1ps
`include "trace_consts.svh"

module trace_reorder_queue(
    input  logic                   clk,
    input  logic                   reset,
    input  trace_pkg::slot_write_t wb_write,
    input  trace_pkg::slot_write_t side_write,
    input  logic                   store_invalidate,
    output trace_pkg::trace_event_t head
);

    localparam int QUEUE_LEN = `TRACE_QUEUE_LEN;

    trace_pkg::trace_event_t slots[QUEUE_LEN];
    trace_pkg::trace_event_t shifted[QUEUE_LEN];
    trace_pkg::trace_event_t next_slots[QUEUE_LEN];
    logic                    wb_conflict;
    logic                    side_conflict;

    always_comb
    begin
        // Every entry advances one slot and the tail fills with nothing
        for (int i = 0; i < QUEUE_LEN - 1; i++)
            shifted[i] = slots[i + 1];

        shifted[QUEUE_LEN - 1] = '0;
        next_slots = shifted;

        if (wb_write.valid)
            next_slots[wb_write.slot] = wb_write.evt;

        if (side_write.valid)
            next_slots[side_write.slot] = side_write.evt;

        // Only a store can be cancelled, a writeback written here is kept
        if (store_invalidate
            && shifted[`TRACE_SLOT_SCYCLE].event_type == trace_pkg::EVENT_STORE)
            next_slots[`TRACE_SLOT_SCYCLE].event_type = trace_pkg::EVENT_INVALID;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < QUEUE_LEN; i++)
                slots[i] <= '0;
        end
        else
            slots <= next_slots;
    end

    assign head = slots[0];

    // A write lands on an occupied entry when the source latencies are wrong
    always_comb
    begin
        wb_conflict = 1'b0;
        side_conflict = 1'b0;
        if (wb_write.valid)
        begin
            if (int'(wb_write.slot) >= QUEUE_LEN)
                wb_conflict = 1'b1;
            else if (shifted[wb_write.slot].event_type != trace_pkg::EVENT_INVALID)
                wb_conflict = 1'b1;
        end

        if (side_write.valid)
        begin
            if (int'(side_write.slot) >= QUEUE_LEN)
                side_conflict = 1'b1;
            else if (shifted[side_write.slot].event_type != trace_pkg::EVENT_INVALID)
                side_conflict = 1'b1;
        end
    end

    // An event written here would overwrite one issued earlier by another pipeline
    wb_slot_free: assert property (@(posedge clk) disable iff (reset) !wb_conflict)
    else
        $error("Writeback event overwrote an in-flight entry at slot %0d", wb_write.slot);

    side_slot_free: assert property (@(posedge clk) disable iff (reset) !side_conflict)
    else
        $error("Store or interrupt overwrote an in-flight entry");

    // Both capture sides must never place events in the same slot at once
    no_double_write: assert property (@(posedge clk) disable iff (reset)
        (wb_write.valid && side_write.valid) |-> (wb_write.slot != side_write.slot))
    else
        $error("Writeback and store/interrupt targeted the same slot");

endmodule

//--- logic/trace_emitter.sv
/*
 * Trace record output
 * Registers the queue head as the outgoing record and stamps each valid
 * record with a wrapping sequence number
 */
`timescale 1ns/1ps
`include "trace_consts.svh"

module trace_emitter(
    input  logic                     clk,
    input  logic                     reset,
    input  trace_pkg::trace_event_t  head,
    output logic                     record_valid,
    output trace_pkg::trace_record_t record
);

    trace_pkg::trace_event_t          record_evt;
    logic [`TRACE_SEQ_WIDTH - 1:0]    record_seq;
    logic [`TRACE_SEQ_WIDTH - 1:0]    seq_count;
    logic                             head_valid;

    assign head_valid = head.event_type != trace_pkg::EVENT_INVALID;

    always_ff @(posedge clk)
    begin
        record_evt <= head;
    end

    // The counter holds the number of the next record to go out, so a gap
    // at the checker shows that a record was lost
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            record_valid <= 1'b0;
            record_seq <= '0;
            seq_count <= '0;
        end
        else
        begin
            record_valid <= head_valid;
            if (head_valid)
            begin
                record_seq <= seq_count;
                seq_count <= seq_count + 1'b1;
            end
        end
    end

    always_comb
    begin
        record.evt = record_evt;
        record.seq = record_seq;
    end

endmodule

//--- logic/trace_unit.sv
/*
 * Retirement trace unit top level
 * Capture of writebacks, stores and interrupts, the reorder queue and
 * the record output stage
 */
`timescale 1ns/1ps

module trace_unit(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       trace_en,
    input  trace_pkg::writeback_info_t wb,
    input  trace_pkg::store_info_t     store,
    input  trace_pkg::mem_status_t     status,
    input  trace_pkg::interrupt_info_t interrupt,
    output logic                       record_valid,
    output trace_pkg::trace_record_t   record
);

    trace_pkg::slot_write_t  wb_write;
    trace_pkg::slot_write_t  side_write;
    logic                    store_invalidate;
    trace_pkg::trace_event_t head;

    writeback_capture i_writeback_capture(
        .wb         (wb),
        .trace_en   (trace_en),
        .slot_write (wb_write)
    );

    memory_trap_capture i_memory_trap_capture(
        .store            (store),
        .status           (status),
        .interrupt        (interrupt),
        .trace_en         (trace_en),
        .slot_write       (side_write),
        .store_invalidate (store_invalidate)
    );

    // Puts the three sources back into issue order
    trace_reorder_queue i_trace_reorder_queue(
        .clk              (clk),
        .reset            (reset),
        .wb_write         (wb_write),
        .side_write       (side_write),
        .store_invalidate (store_invalidate),
        .head             (head)
    );

    trace_emitter i_trace_emitter(
        .clk          (clk),
        .reset        (reset),
        .head         (head),
        .record_valid (record_valid),
        .record       (record)
    );

endmodule

//--- bench/trace_unit_tb.sv
/*
 * Testbench of the retirement trace unit
 * Clock and reset, stimulus for writebacks, stores, interrupts and drops,
 * a reference model holding the expected record of every cycle,
 * and the concurrent assertions that compare the DUT against it
 */
`timescale 1ns/1ps
`include "trace_consts.svh"

module trace_unit_tb;

    localparam int RESET_CYCLES = 3;
    localparam int SETTLE_CYCLES = 3;
    localparam int REORDER_CYCLES = 7;
    localparam int BURST_CYCLES = 40;
    localparam int STORE_CYCLES = 10;
    localparam int ENABLE_CYCLES = 9;
    localparam int STIM_CYCLES = RESET_CYCLES + SETTLE_CYCLES + REORDER_CYCLES
        + BURST_CYCLES + STORE_CYCLES + ENABLE_CYCLES;
    // Longest latency from a driven input to its record is 7 cycles
    localparam int CYCLE_LIMIT = STIM_CYCLES + 7 + 20;
    localparam int MODEL_LEN = 256;

    logic                       clk;
    logic                       reset;
    logic                       trace_en;
    trace_pkg::writeback_info_t wb;
    trace_pkg::store_info_t     store;
    trace_pkg::mem_status_t     status;
    trace_pkg::interrupt_info_t interrupt;
    logic                       record_valid;
    trace_pkg::trace_record_t   record;

    // Expected record indexed by the number of rising edges since reset
    bit                             model_valid[MODEL_LEN];
    trace_pkg::trace_event_t        model_evt[MODEL_LEN];
    int                             cycle;
    int                             watchdog;
    int                             last_index;
    int                             store_index;
    logic [`TRACE_SEQ_WIDTH - 1:0]  seq_base;
    logic                           exp_valid;
    trace_pkg::trace_event_t        exp_evt;
    int                             mismatch_count;
    int                             other_count;
    integer                         seed;

    trace_unit i_dut(
        .clk          (clk),
        .reset        (reset),
        .trace_en     (trace_en),
        .wb           (wb),
        .store        (store),
        .status       (status),
        .interrupt    (interrupt),
        .record_valid (record_valid),
        .record       (record)
    );

    always #20 clk = ~clk;

    // seq_base counts the records expected before the current cycle
    always @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            cycle <= 0;
            seq_base <= '0;
        end
        else
        begin
            cycle <= cycle + 1;
            seq_base <= seq_base + model_valid[cycle];
        end
    end

    always @(posedge clk)
    begin
        watchdog <= watchdog + 1;
        if (watchdog >= CYCLE_LIMIT)
        begin
            other_count++;
            $display("Run stopped at the cycle limit of %0d before the last record", CYCLE_LIMIT);
            $display("%0d mismatches, %0d other errors", mismatch_count, other_count);
            $display("tests failed");
            $finish;
        end
    end

    assign exp_valid = model_valid[cycle];
    assign exp_evt = model_evt[cycle];

    valid_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(record_valid))
    else
    begin
        other_count++;
        $display("record_valid is unknown after reset");
    end

    valid_check: assert property (@(posedge clk) disable iff (reset) record_valid == exp_valid)
    else
    begin
        mismatch_count++;
        $display("MISMATCH record_valid got %h expected %h",
            $sampled(record_valid), $sampled(exp_valid));
    end

    event_check: assert property (@(posedge clk) disable iff (reset)
        record_valid |-> record.evt == exp_evt)
    else
    begin
        mismatch_count++;
        $display("MISMATCH record.evt got %h expected %h",
            $sampled(record.evt), $sampled(exp_evt));
    end

    seq_check: assert property (@(posedge clk) disable iff (reset)
        record_valid |-> record.seq == seq_base)
    else
    begin
        mismatch_count++;
        $display("MISMATCH record.seq got %h expected %h",
            $sampled(record.seq), $sampled(seq_base));
    end

    task automatic clear_inputs();
        wb = '0;
        store = '0;
        status = '0;
        interrupt = '0;
    endtask

    task automatic advance(input int n);
        repeat (n)
        begin
            @(negedge clk);
            clear_inputs();
        end
    endtask

    // Books the expected record at index, refusing a cycle that is already taken
    task automatic claim(input int index, input trace_pkg::trace_event_t evt, output bit ok);
        ok = 1'b1;
        if (trace_en)
        begin
            if (model_valid[index])
                ok = 1'b0;
            else
            begin
                model_valid[index] = 1'b1;
                model_evt[index] = evt;
                if (index > last_index)
                    last_index = index;
            end
        end
    endtask

    // Edges from sampling to the record, one more than the target slot
    function automatic int writeback_latency(input trace_pkg::pipeline_sel_t pipe);
        case (pipe)
            trace_pkg::PIPE_MCYCLE_ARITH:
                return 1;
            trace_pkg::PIPE_MEM:
                return 4;
            default:
                return 5;
        endcase
    endfunction

    task automatic put_writeback(input trace_pkg::pipeline_sel_t pipe, input bit is_vector,
        input bit is_sync);
        trace_pkg::writeback_info_t info;
        trace_pkg::trace_event_t    evt;
        bit                         ok;
        info.en = 1'b1;
        info.is_vector = is_vector;
        info.is_sync_store = is_sync;
        info.pipeline = pipe;
        info.thread_idx = trace_pkg::thread_idx_t'($random(seed));
        info.writeback_reg = trace_pkg::register_idx_t'($random(seed));
        info.pc = $random(seed);
        info.value = {$random(seed), $random(seed), $random(seed), $random(seed)};
        info.mask = trace_pkg::lane_mask_t'($random(seed));
        evt = '0;
        evt.event_type = is_vector ? trace_pkg::EVENT_VWRITEBACK : trace_pkg::EVENT_SWRITEBACK;
        evt.pc = info.pc;
        evt.thread_idx = info.thread_idx;
        evt.writeback_reg = info.writeback_reg;
        evt.mask = trace_pkg::line_mask_t'(info.mask);
        evt.data = info.value;
        ok = 1'b1;
        // The register result of a synchronized store is never traced
        if (!is_sync)
            claim(cycle + 1 + writeback_latency(pipe), evt, ok);
        if (ok)
            wb = info;
    endtask

    task automatic put_store(input trace_pkg::line_mask_t mask, output int index);
        trace_pkg::store_info_t  info;
        trace_pkg::trace_event_t evt;
        bit                      ok;
        info.en = 1'b1;
        info.pc = $random(seed);
        info.thread_idx = trace_pkg::thread_idx_t'($random(seed));
        info.virt_addr = $random(seed);
        info.mask = mask;
        info.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
        evt = '0;
        evt.event_type = trace_pkg::EVENT_STORE;
        evt.pc = info.pc;
        evt.thread_idx = info.thread_idx;
        evt.addr = info.virt_addr & ~trace_pkg::scalar_t'(`CACHE_LINE_BYTES - 1);
        evt.mask = mask;
        evt.data = info.data;
        index = cycle + 7;
        claim(index, evt, ok);
        if (ok)
            store = info;
        if (!ok || !trace_en)
            index = -1;
    endtask

    task automatic put_interrupt();
        trace_pkg::interrupt_info_t info;
        trace_pkg::trace_event_t    evt;
        bit                         ok;
        info.en = 1'b1;
        info.thread_idx = trace_pkg::thread_idx_t'($random(seed));
        info.pc = $random(seed);
        evt = '0;
        evt.event_type = trace_pkg::EVENT_INTERRUPT;
        evt.pc = info.pc;
        evt.thread_idx = info.thread_idx;
        claim(cycle + 7, evt, ok);
        if (ok)
            interrupt = info;
    endtask

    // Store with full line mask, then its status one cycle later
    task automatic store_with_status(input bit is_sync, input bit rollback, input bit success);
        int index;
        put_store('1, index);
        advance(1);
        status.instruction_valid = 1'b1;
        status.is_sync = is_sync;
        status.rollback_en = rollback;
        status.sync_success = success;
        if (index >= 0 && (rollback || (is_sync && !success)))
            model_valid[index] = 1'b0;
        advance(1);
    endtask

    task automatic random_cycle();
        int pick;
        int index;
        pick = $unsigned($random(seed)) % 8;
        if (pick < 5)
            put_writeback(trace_pkg::pipeline_sel_t'($unsigned($random(seed)) % 3),
                1'($random(seed)), 1'b0);
        if (pick == 5 || pick == 7)
            put_store(trace_pkg::line_mask_t'($random(seed)), index);
        else if (pick == 6)
            put_interrupt();
        advance(1);
    endtask

    initial
    begin
        seed = 32'h99c3;
        clk = 1'b0;
        reset = 1'b1;
        trace_en = 1'b1;
        watchdog = 0;
        last_index = 0;
        mismatch_count = 0;
        other_count = 0;
        clear_inputs();
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        advance(SETTLE_CYCLES);

        // A multicycle result driven later comes out one cycle before the single-cycle one
        put_writeback(trace_pkg::PIPE_SCYCLE_ARITH, 1'b0, 1'b0);
        advance(3);
        put_writeback(trace_pkg::PIPE_MCYCLE_ARITH, 1'b1, 1'b0);
        advance(2);
        put_writeback(trace_pkg::PIPE_MCYCLE_ARITH, 1'b0, 1'b0);
        advance(1);
        put_writeback(trace_pkg::PIPE_MEM, 1'b1, 1'b0);
        advance(1);

        repeat (BURST_CYCLES) random_cycle();

        // Plain store, interrupt, then the three synchronized and rollback cases
        store_with_status(1'b0, 1'b0, 1'b0);
        put_interrupt();
        advance(1);
        store_with_status(1'b0, 1'b1, 1'b0);
        store_with_status(1'b1, 1'b0, 1'b0);
        store_with_status(1'b1, 1'b0, 1'b1);
        put_writeback(trace_pkg::PIPE_MEM, 1'b0, 1'b1);
        advance(1);

        // Events in flight keep draining while capture is switched off
        put_store('1, store_index);
        put_writeback(trace_pkg::PIPE_SCYCLE_ARITH, 1'b1, 1'b0);
        advance(1);
        put_writeback(trace_pkg::PIPE_MCYCLE_ARITH, 1'b0, 1'b0);
        advance(1);
        trace_en = 1'b0;
        put_writeback(trace_pkg::PIPE_MEM, 1'b1, 1'b0);
        put_interrupt();
        advance(1);
        put_writeback(trace_pkg::PIPE_SCYCLE_ARITH, 1'b0, 1'b0);
        advance(1);
        put_store('1, store_index);
        advance(3);
        trace_en = 1'b1;
        put_interrupt();
        advance(1);
        put_writeback(trace_pkg::PIPE_MCYCLE_ARITH, 1'b1, 1'b0);
        advance(1);

        wait (cycle > last_index + 2);
        @(negedge clk);
        $display("%0d mismatches, %0d other errors", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

//--- trace_unit.f
+incdir+common
common/trace_pkg.sv
logic/writeback_capture.sv
logic/memory_trap_capture.sv
reorder/trace_reorder_queue.sv
logic/trace_emitter.sv
logic/trace_unit.sv
bench/trace_unit_tb.sv

//--- Bender.yml
package:
  name: trace_unit

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/trace_pkg.sv
      - logic/writeback_capture.sv
      - logic/memory_trap_capture.sv
      - reorder/trace_reorder_queue.sv
      - logic/trace_emitter.sv
      - logic/trace_unit.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - bench/trace_unit_tb.sv
